/* common/rdma_hdr_pkg.sv */
`default_nettype none

package rdma_hdr_pkg;

  // protocol field widths
  typedef logic [47:0] mac_addr_t;
  typedef logic [31:0] ipv4_addr_t;
  typedef logic [23:0] psn_t;
  typedef logic [23:0] qpn_t;
  typedef logic [15:0] ip_csum_t;

  localparam logic [15:0] ETHERTYPE_IPV4 = 16'h0800;

  // ipv4 fixed fields
  localparam logic [7:0]  IP_VER_IHL    = 8'h45;
  localparam logic [7:0]  IP_TOS        = 8'hb8;
  localparam logic [15:0] IP_ID         = 16'h5555;
  localparam logic [15:0] IP_FLAGS_FRAG = 16'h4000;  // don't fragment
  localparam logic [7:0]  IP_TTL        = 8'hba;
  localparam logic [7:0]  IP_PROTO_UDP  = 8'h11;

  localparam logic [15:0] UDP_SRC_PORT = 16'h6851;
  localparam logic [15:0] UDP_DST_PORT = 16'h12b7;  // rocev2

  // base transport header
  localparam logic [7:0]  BTH_OPC_SEND_ONLY = 8'h04;
  localparam logic [7:0]  BTH_OPC_ACK       = 8'h11;
  localparam logic [7:0]  BTH_FLAGS         = 8'h30;
  localparam logic [15:0] BTH_PKEY          = 16'h666f;

  // header lengths in bytes
  localparam int ETH_HDR_BYTES  = 14;
  localparam int IPV4_HDR_BYTES = 20;
  localparam int UDP_HDR_BYTES  = 8;
  localparam int BTH_HDR_BYTES  = 12;
  localparam int AETH_HDR_BYTES = 4;

  localparam int SEND_HDR_BYTES =
    ETH_HDR_BYTES + IPV4_HDR_BYTES + UDP_HDR_BYTES + BTH_HDR_BYTES;
  localparam int ACK_HDR_BYTES      = SEND_HDR_BYTES + AETH_HDR_BYTES;
  localparam int SEND_PAYLOAD_BYTES = 80;
  localparam int HDR_MAX_BYTES      = ACK_HDR_BYTES;

  // byte 0 of the header sits in bits [7:0]
  typedef logic [HDR_MAX_BYTES*8-1:0] hdr_bytes_t;

endpackage

`default_nettype wire

/* common/pkt_gen_pkg.sv */
`default_nettype none

package pkt_gen_pkg;

  // 512-bit stream
  localparam int BEAT_BYTES = 64;

  typedef logic [BEAT_BYTES*8-1:0] beat_data_t;
  typedef logic [BEAT_BYTES-1:0]   beat_keep_t;

  typedef struct packed {
    beat_data_t data;
    beat_keep_t keep;
    logic       last;
  } axis_beat_t;

  typedef enum logic {
    PKT_SEND = 1'b0,
    PKT_ACK  = 1'b1
  } pkt_kind_e;

  typedef logic [7:0] qp_idx_t;    // index into the qp table
  typedef logic [7:0] pay_byte_t;  // fill byte of a send payload

  typedef struct packed {
    pkt_kind_e          kind;
    qp_idx_t            qp_idx;
    rdma_hdr_pkg::psn_t psn;
    pay_byte_t          payload;
  } pkt_desc_t;

  // per queue pair setup
  typedef struct packed {
    rdma_hdr_pkg::mac_addr_t  dst_mac;
    rdma_hdr_pkg::ipv4_addr_t dst_ip;
    rdma_hdr_pkg::qpn_t       qpn;
    rdma_hdr_pkg::psn_t       base_psn;
  } qp_cfg_t;

  typedef struct packed {
    rdma_hdr_pkg::qpn_t qpn;
    rdma_hdr_pkg::psn_t psn;
  } wqe_resp_t;

  typedef enum logic [2:0] {
    SEQ_SEND_REQ,
    SEQ_SEND_WAIT,
    SEQ_WQE_REQ,
    SEQ_WQE_WAIT,
    SEQ_ACK_REQ,
    SEQ_ACK_WAIT,
    SEQ_DONE
  } seq_state_e;

endpackage

`default_nettype wire

/* packet/ipv4_checksum.sv */
`timescale 1ns/1ps
`default_nettype none

module ipv4_checksum (
  input  logic [rdma_hdr_pkg::IPV4_HDR_BYTES*8-1:0] ip_hdr_i,
  output rdma_hdr_pkg::ip_csum_t                    csum_o
);

  import rdma_hdr_pkg::*;

  localparam int NUM_WORDS = IPV4_HDR_BYTES / 2;
  localparam int SUM_W     = 16 + $clog2(NUM_WORDS);

  logic [SUM_W-1:0] sum;

  always_comb begin
    sum = '0;
    for (int w = 0; w < NUM_WORDS; w++) begin
      sum = sum + SUM_W'(ip_hdr_i[w*16 +: 16]);
    end
    // second pass absorbs the carry a first fold can leave
    for (int f = 0; f < 2; f++) begin
      sum = SUM_W'(sum[15:0]) + SUM_W'(sum[SUM_W-1:16]);
    end
  end

  assign csum_o = ~sum[15:0];  // ones complement

endmodule

`default_nettype wire

/* packet/hdr_builder.sv */
`timescale 1ns/1ps
`default_nettype none

module hdr_builder #(
  parameter int NUM_QP = 4
) (
  input  pkt_gen_pkg::pkt_desc_t   pkt_desc_i,
  input  pkt_gen_pkg::qp_cfg_t     qp_cfg_i [NUM_QP],
  input  rdma_hdr_pkg::mac_addr_t  src_mac_i,
  input  rdma_hdr_pkg::ipv4_addr_t src_ip_i,
  output rdma_hdr_pkg::hdr_bytes_t hdr_o
);

  import rdma_hdr_pkg::*;
  import pkt_gen_pkg::*;

  localparam int QP_IDX_W = (NUM_QP > 1) ? $clog2(NUM_QP) : 1;

  qp_cfg_t                   qp;
  logic                      is_ack;
  logic [15:0]               ip_total_len;
  logic [15:0]               udp_len;
  logic [7:0]                opcode;
  logic [IPV4_HDR_BYTES*8-1:0] ip_hdr;
  ip_csum_t                  ip_csum;
  hdr_bytes_t                hdr_be;  // first byte in the msb

  assign qp     = qp_cfg_i[pkt_desc_i.qp_idx[QP_IDX_W-1:0]];
  assign is_ack = (pkt_desc_i.kind == PKT_ACK);
  assign opcode = is_ack ? BTH_OPC_ACK : BTH_OPC_SEND_ONLY;

  assign ip_total_len = is_ack ?
    16'(ACK_HDR_BYTES - ETH_HDR_BYTES) :
    16'(SEND_HDR_BYTES + SEND_PAYLOAD_BYTES - ETH_HDR_BYTES);
  assign udp_len = ip_total_len - 16'(IPV4_HDR_BYTES);

  // checksum field left at zero for the sum
  assign ip_hdr = {IP_VER_IHL, IP_TOS, ip_total_len, IP_ID, IP_FLAGS_FRAG,
                   IP_TTL, IP_PROTO_UDP, 16'h0000, src_ip_i, qp.dst_ip};

  ipv4_checksum u_ipv4_checksum (
    .ip_hdr_i (ip_hdr),
    .csum_o   (ip_csum)
  );

  // trailing four zero bytes are the ack aeth, or unused on a send
  assign hdr_be = {
    qp.dst_mac, src_mac_i, ETHERTYPE_IPV4,
    ip_hdr[IPV4_HDR_BYTES*8-1 -: 80], ip_csum, ip_hdr[63:0],
    UDP_SRC_PORT, UDP_DST_PORT, udp_len, 16'h0000,
    opcode, BTH_FLAGS, BTH_PKEY, 8'h00, qp.qpn, 8'h00, pkt_desc_i.psn,
    32'h0000_0000
  };

  // wire order, byte 0 goes out first
  always_comb begin
    for (int i = 0; i < HDR_MAX_BYTES; i++) begin
      hdr_o[i*8 +: 8] = hdr_be[(HDR_MAX_BYTES-1-i)*8 +: 8];
    end
  end

endmodule

`default_nettype wire

/* packet/beat_serializer.sv */
`timescale 1ns/1ps
`default_nettype none

module beat_serializer #(
  parameter int GAP_CYCLES = 16
) (
  input  logic                     core_clk,
  input  logic                     core_aresetn,
  input  logic                     pkt_req_i,
  output logic                     pkt_ack_o,
  input  pkt_gen_pkg::pkt_desc_t   pkt_desc_i,
  input  rdma_hdr_pkg::hdr_bytes_t hdr_i,
  output pkt_gen_pkg::axis_beat_t  tx_beat_o,
  output logic                     tx_valid_o,
  input  logic                     tx_ready_i
);

  import rdma_hdr_pkg::*;
  import pkt_gen_pkg::*;

  localparam int SEND_PKT_BYTES = SEND_HDR_BYTES + SEND_PAYLOAD_BYTES;
  localparam int MAX_BEATS      = (SEND_PKT_BYTES + BEAT_BYTES - 1) / BEAT_BYTES;
  localparam int BUF_BYTES      = MAX_BEATS * BEAT_BYTES;
  localparam int BEAT_BITS      = $bits(beat_data_t);
  localparam int BEAT_IDX_W     = (MAX_BEATS > 1) ? $clog2(MAX_BEATS) : 1;
  localparam int LEN_W          = $clog2(BUF_BYTES + 1);
  localparam int GAP_W          = $clog2(GAP_CYCLES + 2);

  typedef enum logic [1:0] {
    SER_IDLE,
    SER_STREAM,
    SER_GAP,
    SER_ACK
  } ser_state_e;

  ser_state_e             state;
  logic                   capture;
  logic [BUF_BYTES*8-1:0] pkt_flat;
  logic [LEN_W-1:0]       pkt_len;
  beat_data_t             pkt_buf [MAX_BEATS];
  logic [BEAT_IDX_W-1:0]  beat_idx;
  logic [LEN_W-1:0]       bytes_left;  // from the current beat on
  logic [GAP_W-1:0]       gap_cnt;

  assign capture = (state == SER_IDLE) && pkt_req_i && !pkt_ack_o;
  assign pkt_len = (pkt_desc_i.kind == PKT_ACK) ? LEN_W'(ACK_HDR_BYTES) :
                                                  LEN_W'(SEND_PKT_BYTES);

  // header then payload fill, zero beyond the packet
  always_comb begin
    pkt_flat = '0;
    pkt_flat[$bits(hdr_bytes_t)-1:0] = hdr_i;
    if (pkt_desc_i.kind == PKT_SEND) begin
      for (int i = SEND_HDR_BYTES; i < SEND_PKT_BYTES; i++) begin
        pkt_flat[i*8 +: 8] = pkt_desc_i.payload;
      end
    end
  end

  always_ff @(posedge core_clk) begin
    if (capture) begin
      for (int b = 0; b < MAX_BEATS; b++) begin
        pkt_buf[b] <= pkt_flat[b*BEAT_BITS +: BEAT_BITS];
      end
    end
  end

  always_ff @(posedge core_clk or negedge core_aresetn) begin
    if (!core_aresetn) begin
      state      <= SER_IDLE;
      beat_idx   <= '0;
      bytes_left <= '0;
      gap_cnt    <= '0;
      pkt_ack_o  <= 1'b0;
    end else begin
      case (state)
        SER_IDLE: begin
          if (capture) begin
            beat_idx   <= '0;
            bytes_left <= pkt_len;
            state      <= SER_STREAM;
          end
        end
        SER_STREAM: begin
          if (tx_ready_i) begin
            if (bytes_left <= LEN_W'(BEAT_BYTES)) begin
              gap_cnt <= '0;
              state   <= SER_GAP;
            end else begin
              bytes_left <= bytes_left - LEN_W'(BEAT_BYTES);
              beat_idx   <= beat_idx + 1'b1;
            end
          end
        end
        SER_GAP: begin
          if (gap_cnt == GAP_W'(GAP_CYCLES)) begin
            pkt_ack_o <= 1'b1;
            state     <= SER_ACK;
          end else begin
            gap_cnt <= gap_cnt + 1'b1;
          end
        end
        default: begin
          if (!pkt_req_i) begin
            pkt_ack_o <= 1'b0;
            state     <= SER_IDLE;
          end
        end
      endcase
    end
  end

  assign tx_valid_o = (state == SER_STREAM);

  always_comb begin
    tx_beat_o.data = pkt_buf[beat_idx];
    tx_beat_o.last = (bytes_left <= LEN_W'(BEAT_BYTES));
    if (bytes_left >= LEN_W'(BEAT_BYTES)) begin
      tx_beat_o.keep = '1;
    end else begin
      tx_beat_o.keep = (beat_keep_t'(1) << bytes_left) - beat_keep_t'(1);  // partial tail
    end
  end

  // a stalled beat is held until it transfers
  a_beat_stable: assert property (@(posedge core_clk) disable iff (!core_aresetn)
    tx_valid_o && !tx_ready_i |=> tx_valid_o && $stable(tx_beat_o));

endmodule

`default_nettype wire

/* logic/test_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module test_sequencer #(
  parameter int NUM_QP       = 4,
  parameter int NUM_SEND_PKT = 8,
  parameter int NUM_ACK_PKT  = 8
) (
  input  logic                   core_clk,
  input  logic                   core_aresetn,
  input  logic                   conf_done_i,
  input  pkt_gen_pkg::qp_cfg_t   qp_cfg_i [NUM_QP],
  output logic                   wqe_req_o,
  input  logic                   wqe_ack_i,
  input  pkt_gen_pkg::wqe_resp_t wqe_resp_i,
  output logic                   pkt_req_o,
  input  logic                   pkt_ack_i,
  output pkt_gen_pkg::pkt_desc_t pkt_desc_o,
  output logic                   send_done_o,
  output logic                   ack_done_o
);

  import rdma_hdr_pkg::*;
  import pkt_gen_pkg::*;

  localparam int QP_IDX_W = (NUM_QP > 1) ? $clog2(NUM_QP) : 1;
  localparam int MAX_PKT  = (NUM_SEND_PKT > NUM_ACK_PKT) ? NUM_SEND_PKT : NUM_ACK_PKT;
  localparam int CNT_W    = $clog2(MAX_PKT + 1);

  seq_state_e          state;
  logic [CNT_W-1:0]    pkt_cnt;   // packets done in the current phase
  logic [QP_IDX_W-1:0] qp_sel;    // n mod NUM_QP
  psn_t                round;     // n div NUM_QP
  psn_t                send_psn;
  qp_idx_t             match_idx;
  logic                send_issue;
  logic                wqe_take;

  assign send_psn   = qp_cfg_i[qp_sel].base_psn + round + psn_t'(1);
  assign send_issue = (state == SEQ_SEND_REQ) && conf_done_i && !pkt_ack_i;
  assign wqe_take   = (state == SEQ_WQE_WAIT) && wqe_ack_i;

  // first table entry whose qpn matches, entry 0 otherwise
  always_comb begin
    match_idx = '0;
    for (int i = NUM_QP - 1; i >= 0; i--) begin
      if (qp_cfg_i[i].qpn == wqe_resp_i.qpn) begin
        match_idx = qp_idx_t'(i);
      end
    end
  end

  always_ff @(posedge core_clk or negedge core_aresetn) begin
    if (!core_aresetn) begin
      state       <= SEQ_SEND_REQ;
      pkt_cnt     <= '0;
      qp_sel      <= '0;
      round       <= '0;
      pkt_req_o   <= 1'b0;
      wqe_req_o   <= 1'b0;
      send_done_o <= 1'b0;
      ack_done_o  <= 1'b0;
    end else begin
      case (state)
        SEQ_SEND_REQ: begin
          if (send_issue) begin
            pkt_req_o <= 1'b1;
            state     <= SEQ_SEND_WAIT;
          end
        end
        SEQ_SEND_WAIT: begin
          if (pkt_ack_i) begin
            pkt_req_o <= 1'b0;
            if (pkt_cnt == CNT_W'(NUM_SEND_PKT - 1)) begin
              pkt_cnt     <= '0;
              send_done_o <= 1'b1;
              state       <= SEQ_WQE_REQ;
            end else begin
              pkt_cnt <= pkt_cnt + 1'b1;
              if (qp_sel == QP_IDX_W'(NUM_QP - 1)) begin
                qp_sel <= '0;
                round  <= round + 1'b1;
              end else begin
                qp_sel <= qp_sel + 1'b1;
              end
              state <= SEQ_SEND_REQ;
            end
          end
        end
        SEQ_WQE_REQ: begin
          if (!wqe_ack_i) begin  // previous exchange fully closed
            wqe_req_o <= 1'b1;
            state     <= SEQ_WQE_WAIT;
          end
        end
        SEQ_WQE_WAIT: begin
          if (wqe_take) begin
            wqe_req_o <= 1'b0;
            state     <= SEQ_ACK_REQ;
          end
        end
        SEQ_ACK_REQ: begin
          if (!pkt_ack_i) begin
            pkt_req_o <= 1'b1;
            state     <= SEQ_ACK_WAIT;
          end
        end
        SEQ_ACK_WAIT: begin
          if (pkt_ack_i) begin
            pkt_req_o <= 1'b0;
            if (pkt_cnt == CNT_W'(NUM_ACK_PKT - 1)) begin
              ack_done_o <= 1'b1;
              state      <= SEQ_DONE;
            end else begin
              pkt_cnt <= pkt_cnt + 1'b1;
              state   <= SEQ_WQE_REQ;
            end
          end
        end
        default: begin
          state <= SEQ_DONE;  // run finished
        end
      endcase
    end
  end

  // descriptor held while pkt_req_o is high
  always_ff @(posedge core_clk) begin
    if (send_issue) begin
      pkt_desc_o <= '{kind: PKT_SEND, qp_idx: qp_idx_t'(qp_sel), psn: send_psn,
                      payload: pay_byte_t'(pkt_cnt + 1'b1)};
    end else if (wqe_take) begin
      pkt_desc_o <= '{kind: PKT_ACK, qp_idx: match_idx, psn: wqe_resp_i.psn,
                      payload: '0};
    end
  end

  // the packet path must have answered before a request is withdrawn
  a_req_until_ack: assert property (@(posedge core_clk) disable iff (!core_aresetn)
    $fell(pkt_req_o) |-> $past(pkt_ack_i));

endmodule

`default_nettype wire

/* logic/pkt_gen_top.sv */
`timescale 1ns/1ps
`default_nettype none

module pkt_gen_top #(
  parameter int NUM_QP       = 4,
  parameter int NUM_SEND_PKT = 8,
  parameter int NUM_ACK_PKT  = 8,
  parameter int GAP_CYCLES   = 16
) (
  input  logic                     core_clk,
  input  logic                     core_aresetn,
  input  logic                     conf_done_i,
  input  rdma_hdr_pkg::mac_addr_t  src_mac_i,
  input  rdma_hdr_pkg::ipv4_addr_t src_ip_i,
  input  pkt_gen_pkg::qp_cfg_t     qp_cfg_i [NUM_QP],
  output pkt_gen_pkg::axis_beat_t  tx_beat_o,
  output logic                     tx_valid_o,
  input  logic                     tx_ready_i,
  output logic                     wqe_req_o,
  input  logic                     wqe_ack_i,
  input  pkt_gen_pkg::wqe_resp_t   wqe_resp_i,
  output logic                     send_done_o,
  output logic                     ack_done_o
);

  import rdma_hdr_pkg::*;
  import pkt_gen_pkg::*;

  logic       pkt_req;
  logic       pkt_ack;
  pkt_desc_t  pkt_desc;
  hdr_bytes_t hdr;

  test_sequencer #(
    .NUM_QP       (NUM_QP),
    .NUM_SEND_PKT (NUM_SEND_PKT),
    .NUM_ACK_PKT  (NUM_ACK_PKT)
  ) u_test_sequencer (
    .core_clk     (core_clk),
    .core_aresetn (core_aresetn),
    .conf_done_i  (conf_done_i),
    .qp_cfg_i     (qp_cfg_i),
    .wqe_req_o    (wqe_req_o),
    .wqe_ack_i    (wqe_ack_i),
    .wqe_resp_i   (wqe_resp_i),
    .pkt_req_o    (pkt_req),
    .pkt_ack_i    (pkt_ack),
    .pkt_desc_o   (pkt_desc),
    .send_done_o  (send_done_o),
    .ack_done_o   (ack_done_o)
  );

  hdr_builder #(
    .NUM_QP (NUM_QP)
  ) u_hdr_builder (
    .pkt_desc_i (pkt_desc),
    .qp_cfg_i   (qp_cfg_i),
    .src_mac_i  (src_mac_i),
    .src_ip_i   (src_ip_i),
    .hdr_o      (hdr)
  );

  beat_serializer #(
    .GAP_CYCLES (GAP_CYCLES)
  ) u_beat_serializer (
    .core_clk     (core_clk),
    .core_aresetn (core_aresetn),
    .pkt_req_i    (pkt_req),
    .pkt_ack_o    (pkt_ack),
    .pkt_desc_i   (pkt_desc),
    .hdr_i        (hdr),
    .tx_beat_o    (tx_beat_o),
    .tx_valid_o   (tx_valid_o),
    .tx_ready_i   (tx_ready_i)
  );

endmodule

`default_nettype wire

/* tb/pkt_gen_model.svh */
`ifndef PKT_GEN_MODEL_SVH
`define PKT_GEN_MODEL_SVH

// predicted packet, byte 0 goes out first
logic [7:0] exp_bytes [MAX_BEATS*BEAT_BYTES];
int         exp_len;

// appends a field msb first, as it travels on the wire
task automatic put_field(input logic [47:0] val, input int nbytes);
  for (int i = nbytes - 1; i >= 0; i--) begin
    exp_bytes[exp_len] = val[i*8 +: 8];
    exp_len++;
  end
endtask

function automatic ip_csum_t ip_header_checksum(input int first);
  logic [31:0] sum;
  sum = 32'h0;
  for (int w = 0; w < IPV4_HDR_BYTES / 2; w++) begin
    sum = sum + {16'h0, exp_bytes[first + 2*w], exp_bytes[first + 2*w + 1]};
  end
  while (sum[31:16] != 16'h0) begin
    sum = {16'h0, sum[15:0]} + {16'h0, sum[31:16]};
  end
  return ~sum[15:0];
endfunction

task automatic predict_packet(input pkt_desc_t desc, input qp_cfg_t qp,
                              input mac_addr_t smac, input ipv4_addr_t sip);
  int       ip_len;
  ip_csum_t csum;
  ip_len = (desc.kind == PKT_ACK) ? ACK_HDR_BYTES - ETH_HDR_BYTES :
                                    SEND_HDR_BYTES + SEND_PAYLOAD_BYTES - ETH_HDR_BYTES;
  for (int i = 0; i < MAX_BEATS*BEAT_BYTES; i++) begin
    exp_bytes[i] = 8'h00;
  end
  exp_len = 0;
  put_field(qp.dst_mac, 6);
  put_field(smac, 6);
  put_field(48'(ETHERTYPE_IPV4), 2);
  put_field(48'(IP_VER_IHL), 1);
  put_field(48'(IP_TOS), 1);
  put_field(48'(ip_len), 2);
  put_field(48'(IP_ID), 2);
  put_field(48'(IP_FLAGS_FRAG), 2);
  put_field(48'(IP_TTL), 1);
  put_field(48'(IP_PROTO_UDP), 1);
  put_field(48'h0, 2);  // checksum goes here
  put_field(48'(sip), 4);
  put_field(48'(qp.dst_ip), 4);
  csum = ip_header_checksum(ETH_HDR_BYTES);
  exp_bytes[ETH_HDR_BYTES + 10] = csum[15:8];
  exp_bytes[ETH_HDR_BYTES + 11] = csum[7:0];
  put_field(48'(UDP_SRC_PORT), 2);
  put_field(48'(UDP_DST_PORT), 2);
  put_field(48'(ip_len - IPV4_HDR_BYTES), 2);
  put_field(48'h0, 2);
  // bth
  put_field(48'((desc.kind == PKT_ACK) ? BTH_OPC_ACK : BTH_OPC_SEND_ONLY), 1);
  put_field(48'(BTH_FLAGS), 1);
  put_field(48'(BTH_PKEY), 2);
  put_field(48'h0, 1);
  put_field(48'(qp.qpn), 3);
  put_field(48'h0, 1);
  put_field(48'(desc.psn), 3);
  if (desc.kind == PKT_ACK) begin
    put_field(48'h0, 4);  // aeth
  end else begin
    for (int i = 0; i < SEND_PAYLOAD_BYTES; i++) begin
      put_field(48'(desc.payload), 1);
    end
  end
endtask

`endif

/* tb/tb_pkt_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_pkt_gen;

  import rdma_hdr_pkg::*;
  import pkt_gen_pkg::*;

  localparam int NUM_QP       = 4;
  localparam int NUM_SEND_PKT = 8;
  localparam int NUM_ACK_PKT  = 8;
  localparam int GAP_CYCLES   = 16;
  localparam int MAX_BEATS    = 3;
  localparam int MAX_STALL    = 12;  // longest tready low run expected
  localparam int MAX_ACK_DLY  = 7;
  localparam int CYCLE_LIMIT  = (NUM_SEND_PKT + NUM_ACK_PKT) *
                                (MAX_BEATS + GAP_CYCLES + MAX_STALL + MAX_ACK_DLY) * 4;

  logic       core_clk;
  logic       core_aresetn;
  logic       conf_done_i;
  mac_addr_t  src_mac_i;
  ipv4_addr_t src_ip_i;
  qp_cfg_t    qp_cfg_i [NUM_QP];
  axis_beat_t tx_beat_o;
  logic       tx_valid_o;
  logic       tx_ready_i;
  logic       wqe_req_o;
  logic       wqe_ack_i;
  wqe_resp_t  wqe_resp_i;
  logic       send_done_o;
  logic       ack_done_o;

  integer     seed;
  logic [31:0] rnd;
  int         cycles;
  pkt_desc_t  exp_q [$];  // packets still due, in order
  pkt_desc_t  new_desc;
  axis_beat_t got_beats [MAX_BEATS];
  int         beat_cnt;
  int         send_seen;
  int         ack_seen;
  int         stall_cnt;
  axis_beat_t held_beat;
  logic       stall_pending;
  logic       req_prev;
  logic       ack_prev;
  logic       send_prev;
  logic       ack_done_prev;
  logic       stim_on;
  int         wqe_state;  // 0 idle, 1 delay, 2 ack held
  int         wqe_dly;
  int         err_reset;
  int         err_send;
  int         err_bp;
  int         err_wqe;
  int         err_order;
  int         failed;

  `include "pkt_gen_model.svh"

  pkt_gen_top #(
    .NUM_QP       (NUM_QP),
    .NUM_SEND_PKT (NUM_SEND_PKT),
    .NUM_ACK_PKT  (NUM_ACK_PKT),
    .GAP_CYCLES   (GAP_CYCLES)
  ) u_pkt_gen_top (
    .core_clk     (core_clk),
    .core_aresetn (core_aresetn),
    .conf_done_i  (conf_done_i),
    .src_mac_i    (src_mac_i),
    .src_ip_i     (src_ip_i),
    .qp_cfg_i     (qp_cfg_i),
    .tx_beat_o    (tx_beat_o),
    .tx_valid_o   (tx_valid_o),
    .tx_ready_i   (tx_ready_i),
    .wqe_req_o    (wqe_req_o),
    .wqe_ack_i    (wqe_ack_i),
    .wqe_resp_i   (wqe_resp_i),
    .send_done_o  (send_done_o),
    .ack_done_o   (ack_done_o)
  );

  initial begin
    core_clk = 1'b0;
    forever #50 core_clk = ~core_clk;
  end

  // first table entry with this qpn, -1 if none
  function automatic int table_index(input qpn_t qpn);
    for (int i = 0; i < NUM_QP; i++) begin
      if (qp_cfg_i[i].qpn == qpn) begin
        return i;
      end
    end
    return -1;
  endfunction

  task automatic answer_wqe();
    pkt_desc_t desc;
    qpn_t      qpn;
    int        idx;
    rnd = $random(seed);
    if (rnd[1:0] != 2'b00) begin
      qpn = qp_cfg_i[int'(rnd[7:4]) % NUM_QP].qpn;
    end else begin
      qpn = 24'($random(seed));
      while (table_index(qpn) >= 0) begin
        qpn = 24'($random(seed));
      end
    end
    idx  = table_index(qpn);
    desc = '{kind: PKT_ACK, qp_idx: 8'((idx < 0) ? 0 : idx), psn: 24'($random(seed)),
             payload: 8'h00};
    wqe_resp_i = '{qpn: qpn, psn: desc.psn};
    wqe_ack_i  = 1'b1;
    exp_q.push_back(desc);
  endtask

  task automatic check_packet();
    pkt_desc_t  desc;
    string      name;
    int         nbeats;
    int         rem;
    int         errs;
    int         num;
    beat_keep_t exp_keep;
    beat_data_t exp_data;
    beat_data_t got_data;
    if (exp_q.size() == 0) begin
      err_order++;
      $display("a packet arrived on the stream when none was due");
      return;
    end
    desc = exp_q.pop_front();
    predict_packet(desc, qp_cfg_i[desc.qp_idx], src_mac_i, src_ip_i);
    name   = (desc.kind == PKT_ACK) ? "wqe_ack" : "send_packets";
    num    = (desc.kind == PKT_ACK) ? ack_seen : send_seen;
    nbeats = (exp_len + BEAT_BYTES - 1) / BEAT_BYTES;
    errs   = 0;
    if (beat_cnt != nbeats) begin
      errs++;
      $display("FAILED %s pkt %0d beats: expected %0d, actual %0d", name, num, nbeats,
               beat_cnt);
    end else begin
      for (int b = 0; b < nbeats; b++) begin
        rem      = exp_len - b * BEAT_BYTES;
        exp_keep = '0;
        exp_data = '0;
        got_data = '0;
        for (int i = 0; i < BEAT_BYTES && i < rem; i++) begin
          exp_keep[i]        = 1'b1;
          exp_data[i*8 +: 8] = exp_bytes[b*BEAT_BYTES + i];
          got_data[i*8 +: 8] = got_beats[b].data[i*8 +: 8];
        end
        if (got_beats[b].keep !== exp_keep) begin
          errs++;
          $display("FAILED %s pkt %0d beat %0d keep: expected %h, actual %h", name, num, b,
                   exp_keep, got_beats[b].keep);
        end
        if (got_beats[b].last !== (b == nbeats - 1)) begin
          errs++;
          $display("FAILED %s pkt %0d beat %0d last: expected %0d, actual %0d", name, num, b,
                   b == nbeats - 1, got_beats[b].last);
        end
        if (got_data !== exp_data) begin
          errs++;
          $display("FAILED %s pkt %0d beat %0d data: expected %h, actual %h", name, num, b,
                   exp_data, got_data);
        end
      end
    end
    if (desc.kind == PKT_ACK) begin
      err_wqe += errs;
      ack_seen++;
    end else begin
      err_send += errs;
      send_seen++;
    end
  endtask

  task automatic report_test(input string name, input int errs);
    if (errs == 0) begin
      $display("test %-13s passed", name);
    end else begin
      $display("test %-13s failed with %0d errors", name, errs);
    end
  endtask

  // tready and the wqe responder, driven just after the edge
  always @(posedge core_clk) begin
    #1;
    if (stim_on) begin
      tx_ready_i = ($unsigned($random(seed)) % 10) >= 3;  // low ~30%
      case (wqe_state)
        0: begin
          if (wqe_req_o) begin
            wqe_dly   = $unsigned($random(seed)) % (MAX_ACK_DLY + 1);
            wqe_state = 1;
          end
        end
        1: begin
          if (wqe_dly == 0) begin
            answer_wqe();
            wqe_state = 2;
          end else begin
            wqe_dly--;
          end
        end
        default: begin
          if (!wqe_req_o) begin
            wqe_ack_i = 1'b0;
            wqe_state = 0;
          end
        end
      endcase
    end
  end

  // mid-cycle monitor, values here are what the next edge sees
  always @(negedge core_clk) begin
    if (core_aresetn) begin
      if (stall_pending) begin
        stall_cnt++;
        if (tx_valid_o !== 1'b1) begin
          err_bp++;
          $display("valid dropped while a beat was stalled");
        end else if (tx_beat_o !== held_beat) begin
          err_bp++;
          $display("FAILED back_pressure: expected %h, actual %h", held_beat, tx_beat_o);
        end
      end
      stall_pending = tx_valid_o && !tx_ready_i;
      held_beat     = tx_beat_o;
      if (wqe_req_o && !req_prev && ack_prev) begin
        err_wqe++;
        $display("wqe_req_o rose while wqe_ack_i was still high");
      end
      if (!wqe_req_o && req_prev && !ack_prev) begin
        err_wqe++;
        $display("wqe_req_o fell before wqe_ack_i was seen");
      end
      if (wqe_req_o && !send_done_o) begin
        err_order++;
        $display("wqe_req_o raised before send_done_o");
      end
      if (send_done_o && !send_prev && send_seen != NUM_SEND_PKT) begin
        err_order++;
        $display("send_done_o rose after only %0d SEND packets", send_seen);
      end
      if (ack_done_o && !ack_done_prev && ack_seen != NUM_ACK_PKT) begin
        err_order++;
        $display("ack_done_o rose after only %0d ACK packets", ack_seen);
      end
      req_prev      = wqe_req_o;
      ack_prev      = wqe_ack_i;
      send_prev     = send_done_o;
      ack_done_prev = ack_done_o;
      if (tx_valid_o && tx_ready_i) begin
        if (ack_done_o) begin
          err_order++;
          $display("a beat was sent after ack_done_o");
        end
        if (beat_cnt < MAX_BEATS) begin
          got_beats[beat_cnt] = tx_beat_o;
        end
        beat_cnt++;
        if (tx_beat_o.last) begin
          check_packet();
          beat_cnt = 0;
        end
      end
    end
  end

  always @(posedge core_clk) begin
    cycles = cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout, the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Simulation failed");
      $finish;
    end
  end

  initial begin
    seed          = 32'h3771_cddb;
    cycles        = 0;
    beat_cnt      = 0;
    send_seen     = 0;
    ack_seen      = 0;
    stall_cnt     = 0;
    stall_pending = 1'b0;
    req_prev      = 1'b0;
    ack_prev      = 1'b0;
    send_prev     = 1'b0;
    ack_done_prev = 1'b0;
    stim_on       = 1'b0;
    wqe_state     = 0;
    wqe_dly       = 0;
    err_reset     = 0;
    err_send      = 0;
    err_bp        = 0;
    err_wqe       = 0;
    err_order     = 0;
    core_aresetn  = 1'b0;
    conf_done_i   = 1'b0;
    tx_ready_i    = 1'b0;
    wqe_ack_i     = 1'b0;
    wqe_resp_i    = '0;
    rnd           = $random(seed);
    src_mac_i     = {rnd[15:0], 32'($random(seed))};
    src_ip_i      = $random(seed);
    for (int i = 0; i < NUM_QP; i++) begin
      rnd = $random(seed);
      qp_cfg_i[i].dst_mac  = {rnd[15:0], 32'($random(seed))};
      qp_cfg_i[i].dst_ip   = $random(seed);
      qp_cfg_i[i].qpn      = {rnd[31:16], 8'(i)};  // low byte keeps qpns distinct
      qp_cfg_i[i].base_psn = 24'($random(seed));
    end
    for (int n = 0; n < NUM_SEND_PKT; n++) begin
      new_desc = '{kind: PKT_SEND, qp_idx: 8'(n % NUM_QP),
                   psn: psn_t'(qp_cfg_i[n % NUM_QP].base_psn + 24'(n / NUM_QP) + 24'd1),
                   payload: 8'(n + 1)};
      exp_q.push_back(new_desc);
    end

    repeat (3) @(posedge core_clk);
    #1;
    core_aresetn = 1'b1;
    @(negedge core_clk);
    if ({tx_valid_o, wqe_req_o, send_done_o, ack_done_o} !== 4'b0000) begin
      err_reset++;
      $display("FAILED reset: expected 0000, actual %b%b%b%b", tx_valid_o, wqe_req_o,
               send_done_o, ack_done_o);
    end
    report_test("reset", err_reset);
    stim_on = 1'b1;
    @(posedge core_clk);
    #1;
    conf_done_i = 1'b1;

    wait (ack_done_o === 1'b1);
    repeat (GAP_CYCLES + 8) @(posedge core_clk);
    @(negedge core_clk);
    if (send_seen != NUM_SEND_PKT) begin
      err_send++;
      $display("FAILED send_packets count: expected %0d, actual %0d", NUM_SEND_PKT, send_seen);
    end
    if (ack_seen != NUM_ACK_PKT) begin
      err_wqe++;
      $display("FAILED wqe_ack count: expected %0d, actual %0d", NUM_ACK_PKT, ack_seen);
    end
    if (exp_q.size() != 0) begin
      err_order++;
      $display("%0d expected packets never appeared", exp_q.size());
    end
    if (stall_cnt == 0) begin
      err_bp++;
      $display("tready was never low while a beat was waiting");
    end
    report_test("send_packets", err_send);
    report_test("back_pressure", err_bp);
    report_test("wqe_ack", err_wqe);
    report_test("completion", err_order);
    failed = int'(err_reset != 0) + int'(err_send != 0) + int'(err_bp != 0) +
             int'(err_wqe != 0) + int'(err_order != 0);
    $display("tests run 5, passed %0d, failed %0d", 5 - failed, failed);
    if (failed == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* list.f */
+incdir+tb
common/rdma_hdr_pkg.sv
common/pkt_gen_pkg.sv
packet/ipv4_checksum.sv
packet/hdr_builder.sv
packet/beat_serializer.sv
logic/test_sequencer.sv
logic/pkt_gen_top.sv
tb/tb_pkt_gen.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the packet generator testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/1ps -Wno-fatal \
  --top-module tb_pkt_gen -f list.f -o sim_pkt_gen

sim_out=$(./obj_dir/sim_pkt_gen)
echo "$sim_out"

if grep -q "Simulation completed successfully" <<< "$sim_out"; then
  exit 0
fi
exit 1
